/* Makefile */
SIM := obj_dir/Vmem_subsys_tb

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

$(SIM): filelist.f $(wildcard include/*.svh source/*.sv sim/*.sv)
	verilator --binary --timing --assert --top-module mem_subsys_tb \
		-f filelist.f -o Vmem_subsys_tb

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+include
source/rv32i_types_pkg.sv
source/cache_types_pkg.sv
source/line_bus_if.sv
source/word_port.sv
source/line_arbiter.sv
source/burst_adaptor.sv
source/mem_subsys.sv
sim/mem_subsys_properties.sv
sim/mem_subsys_checker.sv
sim/mem_subsys_tb.sv

/* include/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// bus widths in bits
`define WORD_W          32
`define LINE_W          256
`define BURST_W         64

// line geometry
`define BEATS_PER_LINE  4   // 64-bit beats per line
`define WORDS_PER_LINE  8

`endif

/* sim/mem_subsys_checker.sv */
`timescale 1ns/100ps

module mem_subsys_checker (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        imem_resp_i,
    input  rv32i_types_pkg::rv32i_word  imem_rdata_i,
    input  logic                        dmem_resp_i,
    input  rv32i_types_pkg::rv32i_word  dmem_rdata_i,
    input  logic [7:0]                  imem_name_i,
    input  rv32i_types_pkg::rv32i_word  imem_exp_i,
    input  logic [7:0]                  dmem_name_i,
    input  rv32i_types_pkg::rv32i_word  dmem_exp_i,
    input  logic                        dmem_chk_i,     // low for stores
    input  logic                        pair_i,         // dmem and imem issued together
    output int                          tests_o,
    output int                          errors_o
);
    import rv32i_types_pkg::*;

    logic dmem_seen;    // dmem half of a pair already answered

    task automatic compare_read(input string port, input logic [7:0] name,
                                input rv32i_word exp, input rv32i_word act);
        if (act !== exp) begin
            $display("CHECK FAILED t%02h expected 0x%08h actual 0x%08h", name, exp, act);
            errors_o = errors_o + 1;
        end else begin
            $display("t%02h %s read 0x%08h ok", name, port, act);
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n_i) begin
            tests_o   = 0;
            errors_o  = 0;
            dmem_seen = 1'b0;
        end else begin
            if (dmem_resp_i) begin
                if (dmem_chk_i)
                    compare_read("dmem", dmem_name_i, dmem_exp_i, dmem_rdata_i);
                else
                    $display("t%02h dmem store done", dmem_name_i);
                tests_o = tests_o + 1;
            end
            if (imem_resp_i) begin
                // dmem has priority on a tie
                if (pair_i && !dmem_seen) begin
                    $display("t%02h imem was answered before the dmem access issued with it",
                             imem_name_i);
                    errors_o = errors_o + 1;
                end
                compare_read("imem", imem_name_i, imem_exp_i, imem_rdata_i);
                tests_o = tests_o + 1;
            end
            if (!pair_i)
                dmem_seen = 1'b0;
            else if (dmem_resp_i)
                dmem_seen = 1'b1;
        end
    end

endmodule : mem_subsys_checker

/* sim/mem_subsys_properties.sv */
`timescale 1ns/100ps

module mem_subsys_properties (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        imem_resp_i,
    input  logic                        dmem_resp_i,
    input  rv32i_types_pkg::rv32i_word  bmem_addr_i,
    input  logic                        bmem_read_i,
    input  logic                        bmem_write_i,
    input  logic                        bmem_resp_i
);
    int unsigned fail_cnt = 0;
    logic [2:0]  beats;     // beats moved in the current transfer

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            beats <= '0;
        else if (!(bmem_read_i || bmem_write_i))
            beats <= '0;
        else if (bmem_resp_i)
            beats <= beats + 1'b1;
    end

    imem_resp_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        imem_resp_i |=> !imem_resp_i)
        else begin fail_cnt++; $error("imem resp held longer than one cycle"); end

    dmem_resp_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        dmem_resp_i |=> !dmem_resp_i)
        else begin fail_cnt++; $error("dmem resp held longer than one cycle"); end

    // request must not move before the fourth beat
    bmem_req_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((bmem_read_i || bmem_write_i) && !(bmem_resp_i && beats == 3'd3))
        |=> ($stable(bmem_read_i) && $stable(bmem_write_i) && $stable(bmem_addr_i)))
        else begin fail_cnt++; $error("burst request changed before four beats"); end

    bmem_rw_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(bmem_read_i && bmem_write_i))
        else begin fail_cnt++; $error("burst read and write high together"); end

endmodule : mem_subsys_properties

bind mem_subsys mem_subsys_properties props0 (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .imem_resp_i  (imem_resp_o),
    .dmem_resp_i  (dmem_resp_o),
    .bmem_addr_i  (bmem_addr_o),
    .bmem_read_i  (bmem_read_o),
    .bmem_write_i (bmem_write_o),
    .bmem_resp_i  (bmem_resp_i)
);

/* sim/mem_subsys_tb.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_subsys_tb;
    import rv32i_types_pkg::*;

    localparam int FIELDS    = 7;   // name, port, op, addr, wdata, mask, expected
    localparam int MAX_TESTS = 64;
    localparam int MEM_BEATS = 1024;

    logic                clk = 1'b0;
    logic                arst_n_i;
    rv32i_word           imem_addr, imem_rdata;
    logic                imem_read, imem_resp;
    rv32i_word           dmem_addr, dmem_wdata, dmem_rdata;
    logic                dmem_read, dmem_write, dmem_resp;
    rv32i_mask           dmem_wmask;
    rv32i_word           bmem_addr;
    logic                bmem_read, bmem_write;
    logic [`BURST_W-1:0] bmem_rdata = '0;
    logic [`BURST_W-1:0] bmem_wdata;
    logic                bmem_resp = 1'b0;

    // test context for the checker
    logic [7:0]          imem_name, dmem_name;
    rv32i_word           imem_exp, dmem_exp;
    logic                dmem_chk, pair;
    int                  n_tests, n_errors;

    logic [31:0]         tdata [0:MAX_TESTS*FIELDS-1];
    logic [`BURST_W-1:0] mem_model [0:MEM_BEATS-1];
    int                  ntests;
    int                  issued = 0;    // beats offered in this transfer
    int                  taken = 0;     // beats consumed by the DUT
    logic [31:0]         lfsr_q = 32'h244;
    logic                stall;

    function automatic rv32i_word word_pattern(input rv32i_word a);
        return a ^ 32'hA5A5_0000;
    endfunction

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [9:0] beat_index(input rv32i_word a, input int n);
        return a[12:3] + 10'(n);
    endfunction

    always #5 clk = ~clk;

    mem_subsys dut0 (
        .clk(clk), .arst_n_i(arst_n_i),
        .imem_addr_i(imem_addr), .imem_read_i(imem_read),
        .imem_rdata_o(imem_rdata), .imem_resp_o(imem_resp),
        .dmem_addr_i(dmem_addr), .dmem_read_i(dmem_read), .dmem_write_i(dmem_write),
        .dmem_wmask_i(dmem_wmask), .dmem_wdata_i(dmem_wdata),
        .dmem_rdata_o(dmem_rdata), .dmem_resp_o(dmem_resp),
        .bmem_addr_o(bmem_addr), .bmem_read_o(bmem_read), .bmem_write_o(bmem_write),
        .bmem_rdata_i(bmem_rdata), .bmem_wdata_o(bmem_wdata), .bmem_resp_i(bmem_resp)
    );

    mem_subsys_checker chk0 (
        .clk(clk), .arst_n_i(arst_n_i),
        .imem_resp_i(imem_resp), .imem_rdata_i(imem_rdata),
        .dmem_resp_i(dmem_resp), .dmem_rdata_i(dmem_rdata),
        .imem_name_i(imem_name), .imem_exp_i(imem_exp),
        .dmem_name_i(dmem_name), .dmem_exp_i(dmem_exp), .dmem_chk_i(dmem_chk),
        .pair_i(pair), .tests_o(n_tests), .errors_o(n_errors)
    );

    // burst memory, one beat per cycle with resp high, lfsr pauses
    always @(posedge clk) begin
        if (!arst_n_i) begin
            for (int b = 0; b < MEM_BEATS; b++)
                mem_model[b] <= {word_pattern(rv32i_word'(b*8+4)),
                                 word_pattern(rv32i_word'(b*8))};
            bmem_resp <= 1'b0;
        end else if (bmem_read || bmem_write) begin
            if (bmem_resp) begin
                if (bmem_write)
                    mem_model[beat_index(bmem_addr, taken)] <= bmem_wdata;
                taken = taken + 1;
            end
            if (issued < `BEATS_PER_LINE) begin
                stall  = lfsr_q[0];
                lfsr_q = lfsr_step(lfsr_q);
                if (!stall) begin
                    bmem_rdata <= mem_model[beat_index(bmem_addr, issued)];
                    issued = issued + 1;
                end
                bmem_resp <= !stall;
            end else
                bmem_resp <= 1'b0;
        end else begin
            bmem_resp <= 1'b0;
            issued = 0;
            taken  = 0;
        end
    end

    task automatic launch(input int t);
        logic [31:0] port;
        logic        wr;
        port = tdata[t*FIELDS+1];
        wr   = tdata[t*FIELDS+2][0];
        if (port == 32'd1) begin
            imem_addr <= tdata[t*FIELDS+3];
            imem_read <= 1'b1;
            imem_name <= tdata[t*FIELDS][7:0];
            imem_exp  <= tdata[t*FIELDS+6];
        end else begin
            dmem_addr  <= tdata[t*FIELDS+3];
            dmem_read  <= !wr;
            dmem_write <= wr;
            dmem_wdata <= tdata[t*FIELDS+4];
            dmem_wmask <= tdata[t*FIELDS+5][3:0];
            dmem_name  <= tdata[t*FIELDS][7:0];
            dmem_exp   <= tdata[t*FIELDS+6];
            dmem_chk   <= !wr;
        end
    endtask

    task automatic await_imem();
        @(posedge clk);
        while (!imem_resp)
            @(posedge clk);
        imem_read <= 1'b0;
    endtask

    task automatic await_dmem();
        @(posedge clk);
        while (!dmem_resp)
            @(posedge clk);
        dmem_read  <= 1'b0;
        dmem_write <= 1'b0;
    endtask

    initial begin
        arst_n_i   = 1'b0;
        imem_addr  = '0;
        imem_read  = 1'b0;
        dmem_addr  = '0;
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        dmem_wmask = '0;
        dmem_wdata = '0;
        imem_name  = '0;
        dmem_name  = '0;
        imem_exp   = '0;
        dmem_exp   = '0;
        dmem_chk   = 1'b0;
        pair       = 1'b0;
        $readmemh("sim/mem_subsys_testdata.txt", tdata);
        ntests = 0;
        while (ntests < MAX_TESTS && tdata[ntests*FIELDS] != 32'd0)
            ntests = ntests + 1;
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        for (int t = 0; t < ntests; t++) begin
            @(posedge clk);
            launch(t);
            if (tdata[t*FIELDS+1] == 32'd3 && t + 1 < ntests) begin
                launch(t + 1);      // imem partner in the same cycle
                pair <= 1'b1;
                fork
                    await_dmem();
                    await_imem();
                join
                pair <= 1'b0;
                t++;
            end else if (tdata[t*FIELDS+1] == 32'd1)
                await_imem();
            else
                await_dmem();
        end
        repeat (4) @(posedge clk);
        $display("%0d of %0d tests done, %0d check errors, %0d assertion failures",
                 n_tests, ntests, n_errors, dut0.props0.fail_cnt);
        if (ntests > 0 && n_tests == ntests && n_errors == 0 && dut0.props0.fail_cnt == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // watchdog, 200 cycles per test
    initial begin
        #1;
        repeat (ntests * 200 + 20) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", ntests * 200 + 20);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : mem_subsys_tb

/* sim/mem_subsys_testdata.txt */
// name port op addr wdata mask expected, all hex
// port 1 imem, 2 dmem, 3 dmem issued together with the imem line after it; op 1 is a store
01 1 0 00000040 00000000 0 A5A50040
02 1 0 0000011C 00000000 0 A5A5011C
03 2 0 00000208 00000000 0 A5A50208
04 2 0 000003F4 00000000 0 A5A503F4
05 2 1 00000104 DEADBEEF F 00000000
06 2 0 00000104 00000000 0 DEADBEEF
07 2 0 00000100 00000000 0 A5A50100
08 2 0 00000108 00000000 0 A5A50108
09 2 0 0000011C 00000000 0 A5A5011C
0A 2 1 00000204 11223344 3 00000000
0B 2 0 00000204 00000000 0 A5A53344
0C 2 1 00000204 AABBCCDD C 00000000
0D 2 0 00000204 00000000 0 AABB3344
0E 2 1 00000208 01020304 5 00000000
0F 2 0 00000208 00000000 0 A5020204
10 1 0 00000204 00000000 0 AABB3344
11 3 0 00000104 00000000 0 DEADBEEF
12 1 0 00000300 00000000 0 A5A50300
13 3 1 00000310 CAFEF00D F 00000000
14 1 0 00000310 00000000 0 CAFEF00D
15 2 0 00000310 00000000 0 CAFEF00D
16 2 0 00000314 00000000 0 A5A50314
00 0 0 00000000 00000000 0 00000000

/* source/burst_adaptor.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module burst_adaptor (
    input  logic                        clk,
    input  logic                        arst_n_i,
    line_mem_if.slave                   line,
    output rv32i_types_pkg::rv32i_word  bmem_addr_o,
    output logic                        bmem_read_o,
    output logic                        bmem_write_o,
    input  logic [`BURST_W-1:0]         bmem_rdata_i,
    output logic [`BURST_W-1:0]         bmem_wdata_o,
    input  logic                        bmem_resp_i
);
    import cache_types_pkg::*;

    localparam int unsigned CNT_W = $clog2(`BEATS_PER_LINE);

    burst_state_e     state;
    logic [CNT_W-1:0] beat_cnt;
    logic             last_beat;
    cacheline_t       shift_q;    // outgoing or incoming line

    assign last_beat = bmem_resp_i && (beat_cnt == CNT_W'(`BEATS_PER_LINE - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= BST_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                BST_IDLE: begin
                    beat_cnt <= '0;
                    if (line.read)
                        state <= BST_READ;
                    else if (line.write)
                        state <= BST_WRITE;
                end
                BST_READ, BST_WRITE: begin
                    if (bmem_resp_i)
                        beat_cnt <= beat_cnt + 1'b1;
                    if (last_beat)
                        state <= BST_DONE;
                end
                BST_DONE: state <= BST_IDLE;
                default:  state <= BST_IDLE;
            endcase
        end
    end

    // beats move lowest first, the line shifts right by one beat each time
    always_ff @(posedge clk) begin
        case (state)
            BST_IDLE: begin
                if (line.write)
                    shift_q <= line.wdata;
            end
            BST_READ: begin
                if (bmem_resp_i)
                    shift_q <= {bmem_rdata_i, shift_q[`LINE_W-1:`BURST_W]};
            end
            BST_WRITE: begin
                if (bmem_resp_i)
                    shift_q <= {{`BURST_W{1'b0}}, shift_q[`LINE_W-1:`BURST_W]};
            end
            default: ;
        endcase
    end

    assign bmem_addr_o  = line.addr;    // held by the arbiter until resp
    assign bmem_read_o  = (state == BST_READ);
    assign bmem_write_o = (state == BST_WRITE);
    assign bmem_wdata_o = shift_q[`BURST_W-1:0];

    assign line.rdata = shift_q;
    assign line.resp  = (state == BST_DONE);

endmodule : burst_adaptor

/* source/cache_types_pkg.sv */
`include "mem_defs.svh"

package cache_types_pkg;

    typedef logic [`LINE_W-1:0]   cacheline_t;
    typedef logic [`LINE_W/8-1:0] line_mask_t;  // one bit per byte

    typedef enum logic [2:0] {
        ARB_IDLE,
        ARB_FETCH,   // line read, also first step of a store
        ARB_MERGE,
        ARB_WRITE,
        ARB_RESP
    } arb_state_e;

    typedef enum logic [1:0] {
        BST_IDLE,
        BST_READ,
        BST_WRITE,
        BST_DONE
    } burst_state_e;

endpackage : cache_types_pkg

/* source/line_arbiter.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module line_arbiter (
    input  logic        clk,
    input  logic        arst_n_i,
    line_req_if.server  iport,
    line_req_if.server  dport,
    line_mem_if.master  mem
);
    import rv32i_types_pkg::*;
    import cache_types_pkg::*;

    localparam int unsigned NBYTES = `LINE_W / 8;

    arb_state_e state;
    logic       sel_d;      // 1 while serving dport

    // latched request
    rv32i_word  addr_q;
    mem_op_e    op_q;
    cacheline_t wdata_q;
    line_mask_t wmask_q;
    cacheline_t line_q;     // fetched line, merged in place for stores

    // state sequencing
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= ARB_IDLE;
            sel_d <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (dport.req) begin   // dmem wins a tie
                        sel_d <= 1'b1;
                        state <= ARB_FETCH;
                    end else if (iport.req) begin
                        sel_d <= 1'b0;
                        state <= ARB_FETCH;
                    end
                end
                ARB_FETCH: begin
                    if (mem.resp)
                        state <= (op_q == MEM_WRITE) ? ARB_MERGE : ARB_RESP;
                end
                ARB_MERGE: state <= ARB_WRITE;
                ARB_WRITE: begin
                    if (mem.resp)
                        state <= ARB_RESP;
                end
                ARB_RESP:  state <= ARB_IDLE;
                default:   state <= ARB_IDLE;
            endcase
        end
    end

    // request capture and line data path
    always_ff @(posedge clk) begin
        case (state)
            ARB_IDLE: begin
                if (dport.req) begin
                    addr_q  <= dport.addr;
                    op_q    <= dport.op;
                    wdata_q <= dport.wdata;
                    wmask_q <= dport.wmask;
                end else if (iport.req) begin
                    addr_q  <= iport.addr;
                    op_q    <= iport.op;
                    wdata_q <= iport.wdata;
                    wmask_q <= iport.wmask;
                end
            end
            ARB_FETCH: begin
                if (mem.resp)
                    line_q <= mem.rdata;
            end
            ARB_MERGE: begin
                for (int i = 0; i < NBYTES; i++) begin
                    if (wmask_q[i])
                        line_q[i*8 +: 8] <= wdata_q[i*8 +: 8];
                end
            end
            default: ;
        endcase
    end

    assign mem.addr  = addr_q;
    assign mem.read  = (state == ARB_FETCH);
    assign mem.write = (state == ARB_WRITE);
    assign mem.wdata = line_q;

    // both ports see the same line, only the chosen one gets resp
    assign dport.rdata = line_q;
    assign iport.rdata = line_q;
    assign dport.resp  = (state == ARB_RESP) &&  sel_d;
    assign iport.resp  = (state == ARB_RESP) && !sel_d;

endmodule : line_arbiter

/* source/line_bus_if.sv */
`timescale 1ns/100ps

// line request between a word port and the arbiter
interface line_req_if;
    import rv32i_types_pkg::*;
    import cache_types_pkg::*;

    rv32i_word  addr;   // 32-byte aligned
    logic       req;
    mem_op_e    op;
    cacheline_t wdata;
    line_mask_t wmask;
    cacheline_t rdata;
    logic       resp;   // one cycle, rdata valid with it

    modport client (output addr, req, op, wdata, wmask, input rdata, resp);
    modport server (input addr, req, op, wdata, wmask, output rdata, resp);
endinterface : line_req_if

// whole-line memory access between the arbiter and the burst adaptor
interface line_mem_if;
    import rv32i_types_pkg::*;
    import cache_types_pkg::*;

    rv32i_word  addr;
    logic       read;
    logic       write;
    cacheline_t wdata;
    cacheline_t rdata;
    logic       resp;

    modport master (output addr, read, write, wdata, input rdata, resp);
    modport slave  (input addr, read, write, wdata, output rdata, resp);
endinterface : line_mem_if

/* source/mem_subsys.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_subsys (
    input  logic                        clk,
    input  logic                        arst_n_i,

    // instruction fetch, read only
    input  rv32i_types_pkg::rv32i_word  imem_addr_i,
    input  logic                        imem_read_i,
    output rv32i_types_pkg::rv32i_word  imem_rdata_o,
    output logic                        imem_resp_o,

    // data port
    input  rv32i_types_pkg::rv32i_word  dmem_addr_i,
    input  logic                        dmem_read_i,
    input  logic                        dmem_write_i,
    input  rv32i_types_pkg::rv32i_mask  dmem_wmask_i,
    input  rv32i_types_pkg::rv32i_word  dmem_wdata_i,
    output rv32i_types_pkg::rv32i_word  dmem_rdata_o,
    output logic                        dmem_resp_o,

    // burst memory
    output rv32i_types_pkg::rv32i_word  bmem_addr_o,
    output logic                        bmem_read_o,
    output logic                        bmem_write_o,
    input  logic [`BURST_W-1:0]         bmem_rdata_i,
    output logic [`BURST_W-1:0]         bmem_wdata_o,
    input  logic                        bmem_resp_i
);

    line_req_if imem_line ();
    line_req_if dmem_line ();
    line_mem_if mem_line ();

    word_port #(.WRITABLE(0)) imem_port (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .addr_i   (imem_addr_i),
        .read_i   (imem_read_i),
        .write_i  (1'b0),
        .wmask_i  (4'h0),
        .wdata_i  (32'h0),
        .rdata_o  (imem_rdata_o),
        .resp_o   (imem_resp_o),
        .line     (imem_line)
    );

    word_port #(.WRITABLE(1)) dmem_port (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .addr_i   (dmem_addr_i),
        .read_i   (dmem_read_i),
        .write_i  (dmem_write_i),
        .wmask_i  (dmem_wmask_i),
        .wdata_i  (dmem_wdata_i),
        .rdata_o  (dmem_rdata_o),
        .resp_o   (dmem_resp_o),
        .line     (dmem_line)
    );

    line_arbiter arbiter0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .iport    (imem_line),
        .dport    (dmem_line),
        .mem      (mem_line)
    );

    burst_adaptor adaptor0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .line         (mem_line),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_resp_i  (bmem_resp_i)
    );

endmodule : mem_subsys

/* source/rv32i_types_pkg.sv */
`include "mem_defs.svh"

package rv32i_types_pkg;

    // data or address word of the core
    typedef logic [`WORD_W-1:0] rv32i_word;

    // byte enables of one word
    typedef logic [`WORD_W/8-1:0] rv32i_mask;

    // opcode on a line request
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage : rv32i_types_pkg

/* source/word_port.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module word_port #(
    parameter int unsigned WRITABLE = 1
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  rv32i_types_pkg::rv32i_word  addr_i,
    input  logic                        read_i,
    input  logic                        write_i,
    input  rv32i_types_pkg::rv32i_mask  wmask_i,
    input  rv32i_types_pkg::rv32i_word  wdata_i,
    output rv32i_types_pkg::rv32i_word  rdata_o,
    output logic                        resp_o,
    line_req_if.client                  line
);
    import rv32i_types_pkg::*;
    import cache_types_pkg::*;

    localparam int unsigned OFS_W      = $clog2(`WORDS_PER_LINE);
    localparam int unsigned LINE_OFS_W = $clog2(`LINE_W / 8);
    localparam int unsigned MASK_W     = `WORD_W / 8;

    logic [OFS_W-1:0] word_ofs;
    logic             wr_en;
    cacheline_t       wdata_line;
    line_mask_t       wmask_line;

    assign word_ofs = addr_i[OFS_W+1:2];
    assign wr_en    = (WRITABLE != 0) && write_i;   // imem never writes

    // word and its byte enables placed in their slot
    always_comb begin
        wdata_line = '0;
        wmask_line = '0;
        wdata_line[word_ofs*`WORD_W +: `WORD_W] = wdata_i;
        if (wr_en)
            wmask_line[word_ofs*MASK_W +: MASK_W] = wmask_i;
    end

    assign line.addr  = {addr_i[`WORD_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
    assign line.op    = wr_en ? MEM_WRITE : MEM_READ;
    assign line.wdata = wdata_line;
    assign line.wmask = wmask_line;
    // held low while resp_o is out, client still has the old access up
    assign line.req   = (read_i | wr_en) & ~resp_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            resp_o <= 1'b0;
        else
            resp_o <= line.resp;
    end

    always_ff @(posedge clk) begin
        if (line.resp)
            rdata_o <= line.rdata[word_ofs*`WORD_W +: `WORD_W];
    end

endmodule : word_port
